//--- build.f
rtl/dec_cfg_pkg.sv
rtl/dec_sample_pkg.sv
rtl/cic_decimator.sv
rtl/channel_align_buffer.sv
rtl/sample_decimator.sv
rtl/adc_decimate_top.sv
verification/tb_adc_decimate.sv

//--- rtl/adc_decimate_top.sv
`timescale 1ns/10ps
`default_nettype none

module adc_decimate_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                      adc_clk,
  input  logic                      adc_rst,
  input  dec_cfg_pkg::rate_sel_e    rate_sel,
  input  dec_cfg_pkg::dec_ratio_t   decimation_ratio,
  input  logic                      valid_a,
  input  dec_sample_pkg::adc_raw_t  data_a,
  input  logic                      valid_b,
  input  dec_sample_pkg::adc_raw_t  data_b,
  output dec_sample_pkg::dec_word_t dec_data_a,
  output dec_sample_pkg::dec_word_t dec_data_b,
  output logic                      dec_valid,
  output logic                      overflow
);

  // CIC outputs, one strobe and sample per channel
  logic                         cic_valid_a;
  logic                         cic_valid_b;
  dec_sample_pkg::adc_raw_t     cic_data_a;
  dec_sample_pkg::adc_raw_t     cic_data_b;

  // Aligned pairs from the buffer
  logic                         pair_valid;
  dec_sample_pkg::sample_pair_t pair;

  // ********************
  // Per-channel CIC
  // ********************

  cic_decimator cic_a (
    .adc_clk   (adc_clk),
    .adc_rst   (adc_rst),
    .rate_sel  (rate_sel),
    .in_valid  (valid_a),
    .in_data   (data_a),
    .out_valid (cic_valid_a),
    .out_data  (cic_data_a)
  );

  cic_decimator cic_b (
    .adc_clk   (adc_clk),
    .adc_rst   (adc_rst),
    .rate_sel  (rate_sel),
    .in_valid  (valid_b),
    .in_data   (data_b),
    .out_valid (cic_valid_b),
    .out_data  (cic_data_b)
  );

  // Channels may settle on different cycles, the buffer realigns them
  channel_align_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_align (
    .adc_clk    (adc_clk),
    .adc_rst    (adc_rst),
    .a_valid    (cic_valid_a),
    .a_data     (cic_data_a),
    .b_valid    (cic_valid_b),
    .b_data     (cic_data_b),
    .pair_valid (pair_valid),
    .pair       (pair),
    .overflow   (overflow)
  );

  // Final pair decimation and widening to the output format
  sample_decimator u_decim (
    .adc_clk          (adc_clk),
    .adc_rst          (adc_rst),
    .decimation_ratio (decimation_ratio),
    .pair_valid       (pair_valid),
    .pair             (pair),
    .dec_valid        (dec_valid),
    .dec_data_a       (dec_data_a),
    .dec_data_b       (dec_data_b)
  );

endmodule

`default_nettype wire

//--- rtl/channel_align_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module channel_align_buffer #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                         adc_clk,
  input  logic                         adc_rst,
  input  logic                         a_valid,
  input  dec_sample_pkg::adc_raw_t     a_data,
  input  logic                         b_valid,
  input  dec_sample_pkg::adc_raw_t     b_data,
  output logic                         pair_valid,
  output dec_sample_pkg::sample_pair_t pair,
  output logic                         overflow
);

  // FIFO_DEPTH is a power of two so the pointers wrap by themselves
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int NCH   = dec_sample_pkg::NUM_CH;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  // Index 0 holds channel A and index 1 holds channel B
  dec_sample_pkg::adc_raw_t mem [NCH][FIFO_DEPTH];
  dec_sample_pkg::adc_raw_t push_data [NCH];
  logic push_req [NCH];
  logic full [NCH];
  logic accept [NCH];
  ptr_t wr_ptr [NCH];
  ptr_t rd_ptr [NCH];
  cnt_t fill [NCH];
  logic pop;

  always_comb begin
    push_req[0]  = a_valid;
    push_req[1]  = b_valid;
    push_data[0] = a_data;
    push_data[1] = b_data;
    // Both heads leave together, which keeps the channels matched in order
    pop = (fill[0] != '0) && (fill[1] != '0);
    for (int ch = 0; ch < NCH; ch++) begin
      full[ch]   = (fill[ch] == cnt_t'(FIFO_DEPTH));
      // A full FIFO still takes a sample when its head leaves this cycle
      accept[ch] = push_req[ch] && (!full[ch] || pop);
    end
  end

  // ********************
  // Pointers, fill and flags
  // ********************

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      for (int ch = 0; ch < NCH; ch++) begin
        wr_ptr[ch] <= '0;
        rd_ptr[ch] <= '0;
        fill[ch]   <= '0;
      end
      pair_valid <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        if (accept[ch]) begin
          wr_ptr[ch] <= wr_ptr[ch] + 1'b1;
        end
        if (pop) begin
          rd_ptr[ch] <= rd_ptr[ch] + 1'b1;
        end
        fill[ch] <= fill[ch] + cnt_t'(accept[ch]) - cnt_t'(pop);
        // Dropped push, sticky until the next reset
        if (push_req[ch] && !accept[ch]) begin
          overflow <= 1'b1;
        end
      end
      pair_valid <= pop;
    end
  end

  // Storage and the output pair register
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < NCH; ch++) begin
      if (accept[ch]) begin
        mem[ch][wr_ptr[ch]] <= push_data[ch];
      end
    end
    if (pop) begin
      pair.a <= mem[0][rd_ptr[0]];
      pair.b <= mem[1][rd_ptr[1]];
    end
  end

  for (genvar g = 0; g < NCH; g++) begin : g_fill_check
    a_fill_bound: assert property (
      @(posedge adc_clk) disable iff (adc_rst)
      fill[g] <= cnt_t'(FIFO_DEPTH)
    );
  end

  a_no_pair_after_reset: assert property (
    @(posedge adc_clk) adc_rst |=> !pair_valid
  );

endmodule

`default_nettype wire

//--- rtl/cic_decimator.sv
`timescale 1ns/10ps
`default_nettype none

module cic_decimator (
  input  logic                     adc_clk,
  input  logic                     adc_rst,
  input  dec_cfg_pkg::rate_sel_e   rate_sel,
  input  logic                     in_valid,
  input  dec_sample_pkg::adc_raw_t in_data,
  output logic                     out_valid,
  output dec_sample_pkg::adc_raw_t out_data
);

  // Second order filter grows by 2*log2(R) bits at most
  localparam int ACC_W = dec_sample_pkg::ADC_W + 2 * dec_cfg_pkg::MAX_RATE_LOG2;

  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic [dec_cfg_pkg::MAX_RATE_LOG2-1:0] phase_t;

  logic [1:0] rate_lg;
  logic       bypass;
  logic       group_done;
  phase_t     phase;
  phase_t     phase_last;

  acc_t in_ext;
  acc_t int1;
  acc_t int2;
  acc_t int1_next;
  acc_t int2_next;
  acc_t int2_dly;
  acc_t comb1;
  acc_t comb1_dly;
  acc_t comb2;
  acc_t comb2_scaled;

  // ********************
  // Datapath arithmetic
  // ********************

  always_comb begin
    rate_lg    = dec_cfg_pkg::rate_log2(rate_sel);
    bypass     = (rate_sel == dec_cfg_pkg::RATE_BYPASS);
    // Index of the last input in a group of R
    phase_last = phase_t'((1 << rate_lg) - 1);
    // Greater-or-equal recovers cleanly if the rate drops mid-group
    group_done = (phase >= phase_last);

    // Sign-extend the input to accumulator width
    in_ext = {{(ACC_W - dec_sample_pkg::ADC_W){in_data[dec_sample_pkg::ADC_W-1]}}, in_data};

    // Integrators see the new sample in this very cycle, so the comb
    // result is ready when the group completes
    int1_next = int1 + in_ext;
    int2_next = int2 + int1_next;

    // Comb stages work at the decimated rate
    comb1 = int2_next - int2_dly;
    comb2 = comb1 - comb1_dly;

    // DC gain is R squared, undo it with an arithmetic shift
    comb2_scaled = comb2 >>> {rate_lg, 1'b0};
  end

  // ********************
  // Control state
  // ********************

  // Integrators wrap modulo 2**ACC_W, which the comb differences cancel
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      phase     <= '0;
      int1      <= '0;
      int2      <= '0;
      int2_dly  <= '0;
      comb1_dly <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (in_valid) begin
        if (bypass) begin
          // Straight through, one register of latency
          out_valid <= 1'b1;
          phase     <= '0;
        end else begin
          int1 <= int1_next;
          int2 <= int2_next;
          if (group_done) begin
            // Last input of the group yields one decimated sample
            phase     <= '0;
            int2_dly  <= int2_next;
            comb1_dly <= comb1;
            out_valid <= 1'b1;
          end else begin
            phase <= phase + 1'b1;
          end
        end
      end
    end
  end

  // Output sample register, qualified by out_valid only
  always_ff @(posedge adc_clk) begin
    if (in_valid) begin
      if (bypass) begin
        out_data <= in_data;
      end else if (group_done) begin
        out_data <= comb2_scaled[dec_sample_pkg::ADC_W-1:0];
      end
    end
  end

  // Every output strobe is caused by an input strobe one cycle earlier
  a_out_follows_in: assert property (
    @(posedge adc_clk) disable iff (adc_rst)
    out_valid |-> $past(in_valid)
  );

endmodule

`default_nettype wire

//--- rtl/dec_cfg_pkg.sv
`default_nettype none

// ********************
// Run-time configuration of the decimation path
// ********************

package dec_cfg_pkg;

  // Largest CIC rate is 2**MAX_RATE_LOG2, which also sizes the integrators
  localparam int MAX_RATE_LOG2 = 3;

  // CIC rate selection, taking the place of a filter mask and its enable table
  typedef enum logic [1:0] {
    RATE_BYPASS = 2'd0,
    RATE_2      = 2'd1,
    RATE_4      = 2'd2,
    RATE_8      = 2'd3
  } rate_sel_e;

  // Number of sample pairs dropped between two emitted pairs
  typedef logic [31:0] dec_ratio_t;

  // Log2 of the CIC rate, zero in bypass
  function automatic logic [1:0] rate_log2(input rate_sel_e sel);
    logic [1:0] lg;
    case (sel)
      RATE_2:  lg = 2'd1;
      RATE_4:  lg = 2'd2;
      RATE_8:  lg = 2'd3;
      default: lg = 2'd0;
    endcase
    return lg;
  endfunction

endpackage

`default_nettype wire

//--- rtl/dec_sample_pkg.sv
`default_nettype none

// ********************
// Sample formats along the path
// ********************

package dec_sample_pkg;

  // Width of a raw converter sample
  localparam int ADC_W = 12;

  // Width of a sample at the path output
  localparam int DEC_W = 16;

  // Raw ADC sample in two's complement
  // The CIC output is scaled back into this same range
  typedef logic signed [ADC_W-1:0] adc_raw_t;

  // Output sample, the raw sample sign-extended
  typedef logic signed [DEC_W-1:0] dec_word_t;

  // One aligned sample from each channel
  // Field a sits in the upper half of the packed word
  typedef struct packed {
    adc_raw_t a;
    adc_raw_t b;
  } sample_pair_t;

  // Number of channels that the buffer pairs up
  localparam int NUM_CH = 2;

  // Bits that the output word adds on top of the raw sample
  localparam int EXT_W = DEC_W - ADC_W;

endpackage

`default_nettype wire

//--- rtl/sample_decimator.sv
`timescale 1ns/10ps
`default_nettype none

module sample_decimator (
  input  logic                         adc_clk,
  input  logic                         adc_rst,
  input  dec_cfg_pkg::dec_ratio_t      decimation_ratio,
  input  logic                         pair_valid,
  input  dec_sample_pkg::sample_pair_t pair,
  output logic                         dec_valid,
  output dec_sample_pkg::dec_word_t    dec_data_a,
  output dec_sample_pkg::dec_word_t    dec_data_b
);

  // Pairs seen since the last emitted one
  dec_cfg_pkg::dec_ratio_t pair_count;

  // Set when the current pair is the one to keep
  logic keep_pair;

  // Sign-extended copies of the incoming pair
  dec_sample_pkg::dec_word_t ext_a;
  dec_sample_pkg::dec_word_t ext_b;

  // ********************
  // Selection and widening
  // ********************

  always_comb begin
    // Compare with greater-or-equal so that a ratio lowered at run time
    // never leaves the counter running past it
    keep_pair = pair_valid && (pair_count >= decimation_ratio);

    // Replicate the sign bit into the extra output bits
    ext_a = {{dec_sample_pkg::EXT_W{pair.a[dec_sample_pkg::ADC_W-1]}}, pair.a};
    ext_b = {{dec_sample_pkg::EXT_W{pair.b[dec_sample_pkg::ADC_W-1]}}, pair.b};
  end

  // ********************
  // Ratio counter and strobe
  // ********************

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      pair_count <= '0;
      dec_valid  <= 1'b0;
    end else begin
      // One strobe shared by both channels
      dec_valid <= keep_pair;
      if (keep_pair) begin
        // Kept pair restarts the count
        pair_count <= '0;
      end else if (pair_valid) begin
        pair_count <= pair_count + 1'b1;
      end
    end
  end

  // Output words change only when a pair is kept
  always_ff @(posedge adc_clk) begin
    if (keep_pair) begin
      dec_data_a <= ext_a;
      dec_data_b <= ext_b;
    end
  end

  // With a nonzero ratio at least one pair is dropped between two outputs
  a_single_pulse: assert property (
    @(posedge adc_clk) disable iff (adc_rst)
    (dec_valid && (decimation_ratio != '0)) |=> !dec_valid
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the ADC decimation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module tb_adc_decimate \
  -Mdir obj_dir \
  -o sim_tb_adc_decimate

# A fatal check ends the binary with a nonzero status, the log decides the result
./obj_dir/sim_tb_adc_decimate > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi

//--- verification/tb_adc_decimate.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adc_decimate;

  localparam int FIFO_DEPTH  = 4;
  // Inputs change this long after each rising edge
  localparam int DRV_DLY     = 10;
  // Cycles any wait loop may spend before it gives up
  localparam int WAIT_LIMIT  = 400;

  logic                      adc_clk;
  logic                      adc_rst;
  dec_cfg_pkg::rate_sel_e    rate_sel;
  dec_cfg_pkg::dec_ratio_t   decimation_ratio;
  logic                      valid_a;
  dec_sample_pkg::adc_raw_t  data_a;
  logic                      valid_b;
  dec_sample_pkg::adc_raw_t  data_b;
  dec_sample_pkg::dec_word_t dec_data_a;
  dec_sample_pkg::dec_word_t dec_data_b;
  logic                      dec_valid;
  logic                      overflow;

  // Pairs still owed by the DUT, oldest first
  dec_sample_pkg::sample_pair_t exp_q[$];
  // Settling outputs that are counted but not compared
  int                           skip_left;
  int                           out_count;
  // Only the overrun test lets overflow rise
  logic                         ovf_allowed;
  logic [31:0]                  rng;

  adc_decimate_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .adc_clk          (adc_clk),
    .adc_rst          (adc_rst),
    .rate_sel         (rate_sel),
    .decimation_ratio (decimation_ratio),
    .valid_a          (valid_a),
    .data_a           (data_a),
    .valid_b          (valid_b),
    .data_b           (data_b),
    .dec_data_a       (dec_data_a),
    .dec_data_b       (dec_data_b),
    .dec_valid        (dec_valid),
    .overflow         (overflow)
  );

  // 100 ns clock
  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  // ********************
  // Helpers
  // ********************

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first failed check");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Two's complement value carried into the 16-bit output range
  function automatic dec_sample_pkg::dec_word_t widen(input dec_sample_pkg::adc_raw_t x);
    int v;
    v = int'(x);
    return dec_sample_pkg::dec_word_t'(v);
  endfunction

  // One clock of stimulus on both channels
  task automatic step(input logic va, input dec_sample_pkg::adc_raw_t a,
                      input logic vb, input dec_sample_pkg::adc_raw_t b);
    @(posedge adc_clk);
    #DRV_DLY;
    valid_a = va;
    data_a  = a;
    valid_b = vb;
    data_b  = b;
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, '0);
  endtask

  // Configuration only changes while reset is held
  task automatic apply_reset(input dec_cfg_pkg::rate_sel_e r, input dec_cfg_pkg::dec_ratio_t n);
    @(posedge adc_clk);
    #DRV_DLY;
    adc_rst          = 1'b1;
    valid_a          = 1'b0;
    valid_b          = 1'b0;
    rate_sel         = r;
    decimation_ratio = n;
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    assert (!dec_valid && !overflow) else
      fail_run($sformatf("** Error at %0d ns: in reset dec_valid=%b overflow=%b",
                         $time, dec_valid, overflow));
    exp_q.delete();
    skip_left   = 0;
    out_count   = 0;
    ovf_allowed = 1'b0;
    @(posedge adc_clk);
    #DRV_DLY;
    adc_rst = 1'b0;
    @(negedge adc_clk);
    assert (!dec_valid && !overflow) else
      fail_run($sformatf("** Error at %0d ns: after reset dec_valid=%b overflow=%b",
                         $time, dec_valid, overflow));
  endtask

  // Wait until every owed pair has come out, then watch for strays
  task automatic wait_outputs();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || skip_left != 0) begin
      @(negedge adc_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run($sformatf("Timeout with %0d expected outputs still missing", exp_q.size()));
      end
    end
    repeat (8) idle();
  endtask

  task automatic wait_overflow();
    int cycles;
    cycles = 0;
    while (!overflow) begin
      @(negedge adc_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("Timeout: overflow never rose after channel A overran its FIFO");
      end
    end
  endtask

  task automatic check_count(input int want);
    assert (out_count == want) else
      fail_run($sformatf("** Error at %0d ns: %0d outputs seen, expected %0d",
                         $time, out_count, want));
  endtask

  // ********************
  // Output checking
  // ********************

  // Outputs are sampled mid-cycle, well away from the rising edge
  always @(negedge adc_clk) begin
    dec_sample_pkg::sample_pair_t exp_pair;
    if (!adc_rst && dec_valid) begin
      out_count++;
      if (skip_left > 0) begin
        skip_left--;
      end else if (exp_q.size() == 0) begin
        fail_run("dec_valid pulsed with no expected pair left");
      end else begin
        exp_pair = exp_q.pop_front();
        assert (dec_data_a == widen(exp_pair.a) && dec_data_b == widen(exp_pair.b)) else
          fail_run($sformatf("** Error at %0d ns: got a=%h b=%h, expected a=%h b=%h", $time,
                             dec_data_a, dec_data_b, widen(exp_pair.a), widen(exp_pair.b)));
      end
    end
  end

  a_ovf_low: assert property (
    @(posedge adc_clk) disable iff (adc_rst)
    !ovf_allowed |-> !overflow
  ) else fail_run($sformatf("** Error at %0d ns: overflow=1 with no FIFO overrun", $time));

  // Overflow, once set, holds until reset
  a_ovf_sticky: assert property (
    @(posedge adc_clk) disable iff (adc_rst)
    $past(overflow) |-> overflow
  ) else fail_run($sformatf("** Error at %0d ns: overflow=0 after it was set", $time));

  // ********************
  // Stimulus
  // ********************

  initial begin
    dec_sample_pkg::sample_pair_t p;
    int lag;
    rng              = 32'h49590012;
    adc_rst          = 1'b1;
    rate_sel         = dec_cfg_pkg::RATE_BYPASS;
    decimation_ratio = '0;
    valid_a          = 1'b0;
    data_a           = '0;
    valid_b          = 1'b0;
    data_b           = '0;
    ovf_allowed      = 1'b0;
    skip_left        = 0;
    out_count        = 0;

    // Bypass with ratio 0 returns every pair, random gaps in between
    apply_reset(dec_cfg_pkg::RATE_BYPASS, 0);
    for (int i = 0; i < 24; i++) begin
      rng = xorshift32(rng);
      p.a = rng[11:0];
      p.b = rng[27:16];
      exp_q.push_back(p);
      step(1'b1, p.a, 1'b1, p.b);
      repeat (rng[31:30] % 3) idle();
    end
    idle();
    wait_outputs();
    check_count(24);

    // Ratio 3 keeps pairs 3, 7, 11 and so on
    apply_reset(dec_cfg_pkg::RATE_BYPASS, 3);
    for (int i = 0; i < 20; i++) begin
      rng = xorshift32(rng);
      p.a = rng[11:0];
      p.b = rng[27:16];
      if (i % 4 == 3) begin
        exp_q.push_back(p);
      end
      step(1'b1, p.a, 1'b1, p.b);
      repeat (rng[31:30] % 3) idle();
    end
    idle();
    wait_outputs();
    check_count(5);

    // Rate 4 on constants, 48 inputs give 12 outputs, the first three settle
    apply_reset(dec_cfg_pkg::RATE_4, 0);
    p.a       = 12'h5A3;
    p.b       = 12'hD44;
    skip_left = 3;
    for (int i = 0; i < 9; i++) begin
      exp_q.push_back(p);
    end
    for (int i = 0; i < 48; i++) begin
      rng = xorshift32(rng);
      step(1'b1, p.a, 1'b1, p.b);
      repeat (rng[1:0] % 3) idle();
    end
    idle();
    wait_outputs();
    check_count(12);

    // Channel B trails channel A by 0 to 3 cycles inside each 4-cycle slot
    apply_reset(dec_cfg_pkg::RATE_BYPASS, 0);
    for (int i = 0; i < 16; i++) begin
      rng = xorshift32(rng);
      p.a = rng[11:0];
      p.b = rng[27:16];
      lag = int'(rng[31:30]);
      exp_q.push_back(p);
      for (int c = 0; c < 4; c++) begin
        step(c == 0, p.a, c == lag, p.b);
      end
    end
    idle();
    wait_outputs();
    check_count(16);

    // Channel A alone overruns its FIFO
    apply_reset(dec_cfg_pkg::RATE_BYPASS, 0);
    ovf_allowed = 1'b1;
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      rng = xorshift32(rng);
      step(1'b1, rng[11:0], 1'b0, '0);
    end
    idle();
    wait_overflow();
    repeat (10) idle();
    assert (overflow) else
      fail_run($sformatf("** Error at %0d ns: overflow=0 before reset", $time));
    // The reset task itself checks that overflow clears
    apply_reset(dec_cfg_pkg::RATE_BYPASS, 0);
    repeat (4) idle();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
